//--- logic/ialu_params.svh
// IALU width parameters
`ifndef IALU_PARAMS_SVH
`define IALU_PARAMS_SVH

// Datapath width
`define IALU_XLEN      32

// Shift amount bits taken from operand 2
`define IALU_SHAMT_W   5

// Radix-2 multiplier, one step per operand bit
`define IALU_MUL_STEPS `IALU_XLEN

`endif

//--- logic/ialu_cmd_pkg.sv
// IALU command encoding
package ialu_cmd_pkg;

    // Commands kept from the execute stage
    typedef enum logic [4:0] {
        IALU_CMD_NONE    = 5'd0,   // Idle, reset value
        IALU_CMD_AND     = 5'd1,
        IALU_CMD_OR      = 5'd2,
        IALU_CMD_XOR     = 5'd3,
        IALU_CMD_ADD     = 5'd4,
        IALU_CMD_SUB     = 5'd5,
        IALU_CMD_SUB_LT  = 5'd6,   // Signed less-than
        IALU_CMD_SUB_LTU = 5'd7,   // Unsigned less-than
        IALU_CMD_SUB_EQ  = 5'd8,
        IALU_CMD_SUB_NE  = 5'd9,
        IALU_CMD_SUB_GE  = 5'd10,  // Signed greater-or-equal
        IALU_CMD_SUB_GEU = 5'd11,  // Unsigned greater-or-equal
        IALU_CMD_SLL     = 5'd12,
        IALU_CMD_SRL     = 5'd13,
        IALU_CMD_SRA     = 5'd14,
        IALU_CMD_MUL     = 5'd15,  // Low word
        IALU_CMD_MULH    = 5'd16,  // High word, signed x signed
        IALU_CMD_MULHSU  = 5'd17,  // High word, signed x unsigned
        IALU_CMD_MULHU   = 5'd18   // High word, unsigned x unsigned
    } ialu_cmd_e;

    // Which unit and result format a command uses
    typedef enum logic [2:0] {
        IALU_CLASS_LOGIC = 3'd0,
        IALU_CLASS_ARITH = 3'd1,
        IALU_CLASS_CMP   = 3'd2,
        IALU_CLASS_SHIFT = 3'd3,
        IALU_CLASS_MUL   = 3'd4
    } ialu_class_e;

    typedef struct packed {
        ialu_class_e cls;  // Decoded class
        ialu_cmd_e   cmd;  // Original command
    } ialu_dec_s;

endpackage

//--- logic/ialu_data_pkg.sv
// IALU datapath types
`include "ialu_params.svh"

package ialu_data_pkg;
    import ialu_cmd_pkg::*;

    // Registered request, decoded command plus operands
    typedef struct packed {
        ialu_dec_s             dec;
        logic [`IALU_XLEN-1:0] op1;
        logic [`IALU_XLEN-1:0] op2;
    } ialu_req_s;

    // Main adder flags
    typedef struct packed {
        logic z;  // Zero
        logic s;  // Sign
        logic o;  // Signed overflow
        logic c;  // Carry out, borrow on subtract
    } ialu_flags_s;

    // Unit result
    typedef struct packed {
        logic [`IALU_XLEN-1:0] word;  // Main result word
        logic                  cmp;   // Comparison bit
    } ialu_res_s;

endpackage

//--- logic/ialu_req_stage.sv
// IALU request stage
`timescale 1ns/1ps
`include "ialu_params.svh"

module ialu_req_stage
    import ialu_cmd_pkg::*, ialu_data_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_vd_i,  // Command valid level
    input  ialu_cmd_e             cmd_i,
    input  logic [`IALU_XLEN-1:0] op1_i,
    input  logic [`IALU_XLEN-1:0] op2_i,
    input  logic                  done_i,    // Result registered downstream
    output ialu_req_s             req_o,
    output logic                  launch_o   // One cycle, request is in req_o
);

    logic        busy_q;  // Operation in flight
    logic        accept;  // Request sampled on this edge
    ialu_class_e cls;     // Class of cmd_i

    // Held valid must not relaunch while busy
    assign accept = cmd_vd_i & ~busy_q;

    // ------------------------------------------------
    // Command decode
    // ------------------------------------------------
    always_comb begin
        case (cmd_i)
            IALU_CMD_ADD,
            IALU_CMD_SUB     : cls = IALU_CLASS_ARITH;
            IALU_CMD_SUB_LT,
            IALU_CMD_SUB_LTU,
            IALU_CMD_SUB_EQ,
            IALU_CMD_SUB_NE,
            IALU_CMD_SUB_GE,
            IALU_CMD_SUB_GEU : cls = IALU_CLASS_CMP;
            IALU_CMD_SLL,
            IALU_CMD_SRL,
            IALU_CMD_SRA     : cls = IALU_CLASS_SHIFT;
            IALU_CMD_MUL,
            IALU_CMD_MULH,
            IALU_CMD_MULHSU,
            IALU_CMD_MULHU   : cls = IALU_CLASS_MUL;
            default          : cls = IALU_CLASS_LOGIC;  // AND, OR, XOR, NONE
        endcase
    end

    // ------------------------------------------------
    // Busy tracking and launch pulse
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q   <= 1'b0;
            launch_o <= 1'b0;
        end else begin
            launch_o <= accept;
            if (accept) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;  // Free from the cycle after the result
            end
        end
    end

    // Request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            req_o.dec.cls <= cls;
            req_o.dec.cmd <= cmd_i;
            req_o.op1     <= op1_i;
            req_o.op2     <= op2_i;
        end
    end

endmodule

//--- logic/ialu_alu_core.sv
// IALU main adder, logic and shifter
`timescale 1ns/1ps
`include "ialu_params.svh"

module ialu_alu_core
    import ialu_cmd_pkg::*, ialu_data_pkg::*;
(
    input  ialu_req_s req_i,  // Registered request
    output ialu_res_s res_o   // Combinational result
);

    logic [`IALU_XLEN-1:0]    op1;
    logic [`IALU_XLEN-1:0]    op2;
    ialu_cmd_e                cmd;
    logic                     is_add;       // Only ADD adds, all else subtracts
    logic [`IALU_XLEN:0]      sum;          // Extended sum, MSB is carry
    logic                     op2_eff_sgn;  // Sign of the value actually added
    ialu_flags_s              flags;
    logic                     lt_s;         // Signed less-than
    logic [`IALU_SHAMT_W-1:0] shamt;
    logic [`IALU_XLEN-1:0]    shft_res;
    logic                     cmp;

    assign op1    = req_i.op1;
    assign op2    = req_i.op2;
    assign cmd    = req_i.dec.cmd;
    assign is_add = (cmd == IALU_CMD_ADD);

    // ------------------------------------------------
    // Main adder and flags
    // ------------------------------------------------
    always_comb begin
        if (is_add) begin
            sum = {1'b0, op1} + {1'b0, op2};
        end else begin
            sum = {1'b0, op1} - {1'b0, op2};  // SUB and all comparisons
        end
    end

    assign op2_eff_sgn = is_add ? op2[`IALU_XLEN-1] : ~op2[`IALU_XLEN-1];

    assign flags.z = ~|sum[`IALU_XLEN-1:0];
    assign flags.s = sum[`IALU_XLEN-1];
    // Same-sign inputs giving opposite-sign result
    assign flags.o = (op1[`IALU_XLEN-1] == op2_eff_sgn)
                   & (sum[`IALU_XLEN-1] != op1[`IALU_XLEN-1]);
    assign flags.c = sum[`IALU_XLEN];  // Borrow, op1 < op2 unsigned

    assign lt_s = flags.s ^ flags.o;

    // ------------------------------------------------
    // Shifter
    // ------------------------------------------------
    assign shamt = op2[`IALU_SHAMT_W-1:0];  // Upper bits of op2 ignored

    always_comb begin
        case (cmd)
            IALU_CMD_SRL : shft_res = op1 >> shamt;
            IALU_CMD_SRA : shft_res = $signed(op1) >>> shamt;  // Sign fill
            default      : shft_res = op1 << shamt;
        endcase
    end

    // ------------------------------------------------
    // Result forming
    // ------------------------------------------------
    always_comb begin
        cmp        = 1'b0;
        res_o.word = '0;
        case (cmd)
            IALU_CMD_AND     : res_o.word = op1 & op2;
            IALU_CMD_OR      : res_o.word = op1 | op2;
            IALU_CMD_XOR     : res_o.word = op1 ^ op2;
            IALU_CMD_ADD,
            IALU_CMD_SUB     : res_o.word = sum[`IALU_XLEN-1:0];  // Wraps
            IALU_CMD_SUB_LT  : cmp = lt_s;
            IALU_CMD_SUB_LTU : cmp = flags.c;
            IALU_CMD_SUB_EQ  : cmp = flags.z;
            IALU_CMD_SUB_NE  : cmp = ~flags.z;
            IALU_CMD_SUB_GE  : cmp = ~lt_s;
            IALU_CMD_SUB_GEU : cmp = ~flags.c;
            IALU_CMD_SLL,
            IALU_CMD_SRL,
            IALU_CMD_SRA     : res_o.word = shft_res;
            default          : begin
            end
        endcase
        // Comparison bit zero-extended into the word
        if (req_i.dec.cls == IALU_CLASS_CMP) begin
            res_o.word = {{(`IALU_XLEN-1){1'b0}}, cmp};
        end
        res_o.cmp = cmp;
    end

endmodule

//--- logic/ialu_mul_seq.sv
// IALU sequential radix-2 multiplier
`timescale 1ns/1ps
`include "ialu_params.svh"

module ialu_mul_seq
    import ialu_cmd_pkg::*, ialu_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      launch_i,  // Request valid in req_i
    input  ialu_req_s req_i,
    output ialu_res_s res_o,     // Valid with done_o
    output logic      done_o
);

    localparam int CNT_W = $clog2(`IALU_MUL_STEPS);

    logic                  start;     // Launch of a MUL class command
    logic                  op1_sgn;
    logic                  op2_sgn;
    logic [`IALU_XLEN:0]   op1_ext;   // Multiplicand, one extra sign bit
    logic [`IALU_XLEN:0]   op2_ext;
    logic                  run_q;
    logic [CNT_W-1:0]      cnt_q;     // Step counter
    logic                  hi_q;      // High word requested
    logic                  neg_q;     // Multiplier is negative
    logic [`IALU_XLEN:0]   mcand_q;
    logic [`IALU_XLEN:0]   acc_q;     // Upper partial product
    logic [`IALU_XLEN-1:0] mplier_q;  // Multiplier, low product bits shift in
    logic                  last;
    logic [`IALU_XLEN:0]   addend;
    logic [`IALU_XLEN+1:0] sum;

    assign start   = launch_i & (req_i.dec.cls == IALU_CLASS_MUL);

    // Op1 signed for MULH and MULHSU, op2 for MULH only
    assign op1_sgn = (req_i.dec.cmd == IALU_CMD_MULH) | (req_i.dec.cmd == IALU_CMD_MULHSU);
    assign op2_sgn = (req_i.dec.cmd == IALU_CMD_MULH);
    assign op1_ext = {op1_sgn & req_i.op1[`IALU_XLEN-1], req_i.op1};
    assign op2_ext = {op2_sgn & req_i.op2[`IALU_XLEN-1], req_i.op2};

    // ------------------------------------------------
    // Shift-add step
    // ------------------------------------------------
    assign last   = (cnt_q == CNT_W'(`IALU_MUL_STEPS - 1));
    assign addend = mplier_q[0] ? mcand_q : '0;

    always_comb begin
        // MSB of a negative multiplier weighs minus, so subtract it
        if (last && neg_q) begin
            sum = {acc_q[`IALU_XLEN], acc_q} - {addend[`IALU_XLEN], addend};
        end else begin
            sum = {acc_q[`IALU_XLEN], acc_q} + {addend[`IALU_XLEN], addend};
        end
    end

    // Step control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            run_q  <= 1'b0;
            cnt_q  <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= run_q & last;  // Result lands together with done
            if (start) begin
                run_q <= 1'b1;
                cnt_q <= '0;
            end else if (run_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (last) begin
                    run_q <= 1'b0;
                end
            end
        end
    end

    // Datapath, loaded on start
    always_ff @(posedge clk) begin
        if (start) begin
            mcand_q  <= op1_ext;
            mplier_q <= op2_ext[`IALU_XLEN-1:0];
            neg_q    <= op2_ext[`IALU_XLEN];
            hi_q     <= (req_i.dec.cmd != IALU_CMD_MUL);
            acc_q    <= '0;
        end else if (run_q) begin
            acc_q    <= sum[`IALU_XLEN+1:1];                     // Arithmetic shift
            mplier_q <= {sum[0], mplier_q[`IALU_XLEN-1:1]};
            if (last) begin
                res_o.word <= hi_q ? sum[`IALU_XLEN:1]
                                   : {sum[0], mplier_q[`IALU_XLEN-1:1]};
                res_o.cmp  <= 1'b0;
            end
        end
    end

endmodule

//--- logic/ialu_rsp_stage.sv
// IALU response stage
`timescale 1ns/1ps
`include "ialu_params.svh"

module ialu_rsp_stage
    import ialu_cmd_pkg::*, ialu_data_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  launch_i,    // Request launched last edge
    input  ialu_class_e           class_i,     // Class of the launched request
    input  ialu_res_s             alu_res_i,   // Combinational core result
    input  ialu_res_s             mul_res_i,
    input  logic                  mul_done_i,
    output logic [`IALU_XLEN-1:0] main_res_o,
    output logic                  cmp_res_o,
    output logic                  res_rdy_o,   // One-cycle result strobe
    output logic                  done_o       // Frees the request stage
);

    logic      take_alu;  // Core result ready this cycle
    logic      take;      // Any result ready this cycle
    ialu_res_s sel;
    logic      rdy_q;

    // ------------------------------------------------
    // Result select
    // ------------------------------------------------
    // Core answers in the launch cycle, multiplier waits for mul_done_i
    assign take_alu = launch_i & (class_i != IALU_CLASS_MUL);
    assign take     = take_alu | mul_done_i;
    assign sel      = take_alu ? alu_res_i : mul_res_i;

    // ------------------------------------------------
    // Output register
    // ------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            main_res_o <= '0;
            cmp_res_o  <= 1'b0;
            rdy_q      <= 1'b0;
        end else begin
            rdy_q <= take;
            if (take) begin
                main_res_o <= sel.word;  // Held until next result
                cmp_res_o  <= sel.cmp;
            end
        end
    end

    assign res_rdy_o = rdy_q;
    assign done_o    = rdy_q;  // Same edge as the strobe

endmodule

//--- logic/ialu_top.sv
// IALU top level
`timescale 1ns/1ps
`include "ialu_params.svh"

module ialu_top
    import ialu_cmd_pkg::*, ialu_data_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  cmd_vd_i,    // Held until res_rdy_o
    input  ialu_cmd_e             cmd_i,
    input  logic [`IALU_XLEN-1:0] op1_i,
    input  logic [`IALU_XLEN-1:0] op2_i,
    output logic [`IALU_XLEN-1:0] main_res_o,
    output logic                  cmp_res_o,
    output logic                  res_rdy_o
);

    ialu_req_s req;       // Registered request
    logic      launch;    // Request start pulse
    ialu_res_s alu_res;
    ialu_res_s mul_res;
    logic      mul_done;
    logic      rsp_done;  // Result registered

    ialu_req_stage u_req (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_vd_i (cmd_vd_i),
        .cmd_i    (cmd_i),
        .op1_i    (op1_i),
        .op2_i    (op2_i),
        .done_i   (rsp_done),
        .req_o    (req),
        .launch_o (launch)
    );

    ialu_alu_core u_core (
        .req_i (req),
        .res_o (alu_res)
    );

    ialu_mul_seq u_mul (
        .clk      (clk),
        .rst_n    (rst_n),
        .launch_i (launch),
        .req_i    (req),
        .res_o    (mul_res),
        .done_o   (mul_done)
    );

    ialu_rsp_stage u_rsp (
        .clk        (clk),
        .rst_n      (rst_n),
        .launch_i   (launch),
        .class_i    (req.dec.cls),
        .alu_res_i  (alu_res),
        .mul_res_i  (mul_res),
        .mul_done_i (mul_done),
        .main_res_o (main_res_o),
        .cmp_res_o  (cmp_res_o),
        .res_rdy_o  (res_rdy_o),
        .done_o     (rsp_done)
    );

endmodule

//--- verif/ialu_asserts.sv
// IALU handshake checks
`timescale 1ns/1ps
`include "ialu_params.svh"

module ialu_asserts
    import ialu_cmd_pkg::*;
(
    input logic                  clk,
    input logic                  rst_n,
    input logic                  cmd_vd_i,
    input ialu_cmd_e             cmd_i,
    input logic [`IALU_XLEN-1:0] main_res_i,
    input logic                  cmp_res_i,
    input logic                  res_rdy_i
);

    logic busy_q;        // Request taken, result strobe not yet seen
    logic nm_take;       // Non-multiply request sampled while idle
    int   fail_cnt = 0;  // Failed assertion count

    assign nm_take = cmd_vd_i & ~busy_q & (cmd_i < IALU_CMD_MUL);

    // Idle tracking seen from the pins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (cmd_vd_i && !busy_q) begin
            busy_q <= 1'b1;
        end else if (res_rdy_i) begin
            busy_q <= 1'b0;  // Free on the edge after the strobe
        end
    end

    // --------------------------------------------------
    // Output protocol
    // --------------------------------------------------
    a_rdy_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        res_rdy_i |=> !res_rdy_i)
        else begin
            $error("res_rdy_o high for two cycles in a row");
            fail_cnt++;
        end

    a_alu_latency : assert property (@(posedge clk) disable iff (!rst_n)
        $past(nm_take, 2) |-> res_rdy_i)
        else begin
            $error("non-multiply result missing two edges after the request");
            fail_cnt++;
        end

    a_no_x : assert property (@(posedge clk) disable iff (!rst_n)
        res_rdy_i |-> !$isunknown({main_res_i, cmp_res_i}))
        else begin
            $error("unknown result bits while res_rdy_o is high");
            fail_cnt++;
        end

endmodule

bind ialu_top ialu_asserts u_asserts (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_vd_i   (cmd_vd_i),
    .cmd_i      (cmd_i),
    .main_res_i (main_res_o),
    .cmp_res_i  (cmp_res_o),
    .res_rdy_i  (res_rdy_o)
);

//--- verif/ialu_tb.sv
// IALU directed testbench
`timescale 1ns/1ps
`include "ialu_params.svh"

module ialu_tb
    import ialu_cmd_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int MUL_BOUND  = `IALU_MUL_STEPS + 3;        // Edges to a multiply result
    localparam int NUM_REQ    = 40 + 48 + 24 + 32 + 5;      // Arith, cmp, shift, mul, handshake
    localparam logic [`IALU_XLEN-1:0] ZERO_V = '0;
    localparam logic [`IALU_XLEN-1:0] ONE_V  = `IALU_XLEN'(1);
    localparam logic [`IALU_XLEN-1:0] ONES_V = '1;
    localparam logic [`IALU_XLEN-1:0] MIN_V  = {1'b1, {(`IALU_XLEN-1){1'b0}}};
    localparam logic [`IALU_XLEN-1:0] MAX_V  = ~MIN_V;

    logic                  clk;
    logic                  rst_n;
    logic                  cmd_vd_i;
    ialu_cmd_e             cmd_i;
    logic [`IALU_XLEN-1:0] op1_i;
    logic [`IALU_XLEN-1:0] op2_i;
    logic [`IALU_XLEN-1:0] main_res_o;
    logic                  cmp_res_o;
    logic                  res_rdy_o;

    logic [31:0] lfsr_q;        // Random source state
    string       cur_test;
    int          test_errs;     // Errors in the running test
    int          err_cnt = 0;
    int          check_cnt = 0;
    int          test_cnt = 0;
    int          extra_pulses;  // Strobes seen while valid is held

    ialu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // --------------------------------------------------
    // Random operands, Galois LFSR
    // --------------------------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [`IALU_XLEN-1:0] rand_word();
        logic [`IALU_XLEN-1:0] w;
        for (int i = 0; i < `IALU_XLEN; i++) begin
            lfsr_q = lfsr_next(lfsr_q);  // One step per bit
            w[i]   = lfsr_q[0];
        end
        return w;
    endfunction

    // Expected {word, cmp} from the instruction semantics
    function automatic logic [`IALU_XLEN:0] model(input ialu_cmd_e c,
                                                  input logic [`IALU_XLEN-1:0] a,
                                                  input logic [`IALU_XLEN-1:0] b);
        logic [2*`IALU_XLEN-1:0] a64;
        logic [2*`IALU_XLEN-1:0] b64;
        logic [2*`IALU_XLEN-1:0] p;
        logic [`IALU_SHAMT_W-1:0] sh;
        logic [`IALU_XLEN-1:0]    w;
        logic                     lt;
        logic                     ltu;
        logic                     cb;
        sh  = b[`IALU_SHAMT_W-1:0];
        lt  = $signed(a) < $signed(b);
        ltu = a < b;
        // Op1 signed for MULH/MULHSU, op2 for MULH
        a64 = (c == IALU_CMD_MULH || c == IALU_CMD_MULHSU) ?
              {{`IALU_XLEN{a[`IALU_XLEN-1]}}, a} : {{`IALU_XLEN{1'b0}}, a};
        b64 = (c == IALU_CMD_MULH) ?
              {{`IALU_XLEN{b[`IALU_XLEN-1]}}, b} : {{`IALU_XLEN{1'b0}}, b};
        p   = a64 * b64;  // Modulo 2^64 is exact for the low 64 bits
        w   = '0;
        cb  = 1'b0;
        case (c)
            IALU_CMD_AND     : w = a & b;
            IALU_CMD_OR      : w = a | b;
            IALU_CMD_XOR     : w = a ^ b;
            IALU_CMD_ADD     : w = a + b;
            IALU_CMD_SUB     : w = a - b;
            IALU_CMD_SUB_LT  : cb = lt;
            IALU_CMD_SUB_LTU : cb = ltu;
            IALU_CMD_SUB_EQ  : cb = (a == b);
            IALU_CMD_SUB_NE  : cb = (a != b);
            IALU_CMD_SUB_GE  : cb = ~lt;
            IALU_CMD_SUB_GEU : cb = ~ltu;
            IALU_CMD_SLL     : w = a << sh;
            IALU_CMD_SRL     : w = a >> sh;
            IALU_CMD_SRA     : w = (a >> sh) | ({`IALU_XLEN{a[`IALU_XLEN-1]}} & ~(ONES_V >> sh));
            IALU_CMD_MUL     : w = p[`IALU_XLEN-1:0];
            default          : w = p[2*`IALU_XLEN-1:`IALU_XLEN];  // High word
        endcase
        if (c >= IALU_CMD_SUB_LT && c <= IALU_CMD_SUB_GEU) begin
            w = `IALU_XLEN'(cb);
        end
        return {w, cb};
    endfunction

    // --------------------------------------------------
    // Checks and reporting
    // --------------------------------------------------
    task automatic note_fail();
        test_errs++;
        err_cnt++;
    endtask

    task automatic compare_word(input string nm, input logic [`IALU_XLEN-1:0] exp,
                                input logic [`IALU_XLEN-1:0] act);
        check_cnt++;
        if (act !== exp) begin
            $display("** Error: %s word expected %h actual %h", nm, exp, act);
            note_fail();
        end
    endtask

    task automatic compare_cmp(input string nm, input logic exp, input logic act);
        check_cnt++;
        if (act !== exp) begin
            $display("** Error: %s bit expected %b actual %b", nm, exp, act);
            note_fail();
        end
    endtask

    task automatic compare_count(input string nm, input int exp, input int act);
        check_cnt++;
        if (act != exp) begin
            $display("** Error: %s count expected %0d actual %0d", nm, exp, act);
            note_fail();
        end
    endtask

    task automatic begin_test(input string nm);
        cur_test  = nm;
        test_errs = 0;
    endtask

    task automatic end_test();
        test_cnt++;
        $display("[%s] %s, %0d errors", (test_errs == 0) ? "PASS" : "FAIL", cur_test, test_errs);
    endtask

    // One request, called on a falling edge with valid low
    task automatic run_req(input ialu_cmd_e c, input logic [`IALU_XLEN-1:0] a,
                           input logic [`IALU_XLEN-1:0] b, input logic hold);
        logic [`IALU_XLEN:0] exp;
        string               nm;
        int                  n;
        nm       = {cur_test, "/", c.name()};
        exp      = model(c, a, b);
        cmd_i    = c;
        op1_i    = a;
        op2_i    = b;
        cmd_vd_i = 1'b1;
        n        = 0;
        while (!res_rdy_o && n < MUL_BOUND + 5) begin
            @(posedge clk);
            n++;              // Edges since the request was driven
            @(negedge clk);
        end
        if (!res_rdy_o) begin
            $display("%s: no result strobe within %0d cycles", nm, n);
            note_fail();
        end else begin
            compare_word(nm, exp[`IALU_XLEN:1], main_res_o);
            compare_cmp(nm, exp[0], cmp_res_o);
            if (c >= IALU_CMD_MUL) begin
                if (n > MUL_BOUND) begin
                    $display("%s: multiply took %0d edges, limit %0d", nm, n, MUL_BOUND);
                    note_fail();
                end
            end else begin
                compare_count(nm, 2, n);
            end
        end
        if (hold) begin
            @(negedge clk);   // Valid stays high past the strobe
            extra_pulses += int'(res_rdy_o);
        end
        cmd_vd_i = 1'b0;
        @(negedge clk);       // At least one low cycle
        if (hold) begin
            extra_pulses += int'(res_rdy_o);  // Relaunch on the held edge shows here
        end
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic test_reset();
        begin_test("reset");
        compare_cmp("reset/res_rdy_o", 1'b0, res_rdy_o);
        compare_word("reset/main_res_o", ZERO_V, main_res_o);
        compare_cmp("reset/cmp_res_o", 1'b0, cmp_res_o);
        end_test();
    endtask

    task automatic test_arith();
        ialu_cmd_e             ops [5];
        logic [`IALU_XLEN-1:0] ea [4];
        logic [`IALU_XLEN-1:0] eb [4];
        begin_test("arith_logic");
        ops = '{IALU_CMD_ADD, IALU_CMD_SUB, IALU_CMD_AND, IALU_CMD_OR, IALU_CMD_XOR};
        ea  = '{ZERO_V, ONES_V, MIN_V, MIN_V};
        eb  = '{ONES_V, ONES_V, ONES_V, MIN_V};  // Wrap cases
        foreach (ops[i]) begin
            for (int j = 0; j < 8; j++) begin
                if (j < 4)
                    run_req(ops[i], ea[j], eb[j], 1'b0);
                else
                    run_req(ops[i], rand_word(), rand_word(), 1'b0);
            end
        end
        end_test();
    endtask

    task automatic test_compare();
        ialu_cmd_e             ops [6];
        logic [`IALU_XLEN-1:0] pa [8];
        logic [`IALU_XLEN-1:0] pb [8];
        begin_test("compare");
        ops = '{IALU_CMD_SUB_LT, IALU_CMD_SUB_LTU, IALU_CMD_SUB_EQ,
                IALU_CMD_SUB_NE, IALU_CMD_SUB_GE, IALU_CMD_SUB_GEU};
        pa  = '{ZERO_V, ZERO_V, ONES_V, ONE_V, MIN_V, MAX_V, MIN_V, ONES_V};
        pb  = '{ZERO_V, ONE_V, ONE_V, ONES_V, MAX_V, MIN_V, ONES_V, MIN_V};  // Mixed signs
        foreach (ops[i]) begin
            foreach (pa[j]) begin
                run_req(ops[i], pa[j], pb[j], 1'b0);
            end
        end
        end_test();
    endtask

    task automatic test_shift();
        ialu_cmd_e             ops [3];
        logic [`IALU_XLEN-1:0] amt [4];
        logic [`IALU_XLEN-1:0] a;
        begin_test("shift");
        ops = '{IALU_CMD_SLL, IALU_CMD_SRL, IALU_CMD_SRA};
        amt = '{ZERO_V, ONE_V, `IALU_XLEN'(31), ~`IALU_XLEN'(30)};  // Last has upper bits set
        foreach (ops[i]) begin
            for (int j = 0; j < 8; j++) begin
                a = rand_word() | (j[0] ? MIN_V : ZERO_V);  // Negative half the time
                run_req(ops[i], a, (j < 4) ? amt[j] : rand_word(), 1'b0);
            end
        end
        end_test();
    endtask

    task automatic test_mul();
        ialu_cmd_e             ops [4];
        logic [`IALU_XLEN-1:0] ea [4];
        logic [`IALU_XLEN-1:0] eb [4];
        begin_test("multiply");
        ops = '{IALU_CMD_MUL, IALU_CMD_MULH, IALU_CMD_MULHSU, IALU_CMD_MULHU};
        ea  = '{MIN_V, MIN_V, ONES_V, MAX_V};
        eb  = '{MIN_V, ONES_V, ONES_V, MIN_V};
        foreach (ops[i]) begin
            for (int j = 0; j < 8; j++) begin
                if (j < 4)
                    run_req(ops[i], ea[j], eb[j], 1'b0);
                else
                    run_req(ops[i], rand_word(), rand_word(), 1'b0);
            end
        end
        end_test();
    endtask

    task automatic test_handshake();
        begin_test("handshake");
        extra_pulses = 0;
        run_req(IALU_CMD_ADD, rand_word(), rand_word(), 1'b1);
        repeat (4) begin
            @(negedge clk);
            extra_pulses += int'(res_rdy_o);  // Nothing may follow the first strobe
        end
        compare_count("handshake/held_valid", 1, 1 + extra_pulses);
        // Back to back, one low cycle between
        run_req(IALU_CMD_MUL, rand_word(), rand_word(), 1'b0);
        run_req(IALU_CMD_SUB_LT, rand_word(), rand_word(), 1'b0);
        run_req(IALU_CMD_XOR, rand_word(), rand_word(), 1'b0);
        run_req(IALU_CMD_SRA, MIN_V | rand_word(), rand_word(), 1'b0);
        end_test();
    endtask

    // --------------------------------------------------
    // Sequence and watchdog
    // --------------------------------------------------
    initial begin
        rst_n    = 1'b0;
        cmd_vd_i = 1'b0;
        cmd_i    = IALU_CMD_NONE;
        op1_i    = '0;
        op2_i    = '0;
        lfsr_q   = 32'hef2f_9486;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_arith();
        test_compare();
        test_shift();
        test_mul();
        test_handshake();
        err_cnt += UUT.u_asserts.fail_cnt;  // Bound handshake checks
        $display("Tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * NUM_REQ * (`IALU_MUL_STEPS + 10));
        $display("Watchdog expired before the tests completed");
        $display("Something failed");
        $finish;
    end

endmodule

//--- project.f
+incdir+logic
logic/ialu_cmd_pkg.sv
logic/ialu_data_pkg.sv
logic/ialu_req_stage.sv
logic/ialu_alu_core.sv
logic/ialu_mul_seq.sv
logic/ialu_rsp_stage.sv
logic/ialu_top.sv
verif/ialu_asserts.sv
verif/ialu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := ialu_tb
FILELIST  := project.f
OBJ_DIR   := obj_dir
PASS_MSG  := Everything OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
